/* hdl/avmm_pkg.sv */
// Shared widths, depths, opcodes and request/response structs for the memory slave.
// Modules import this package wherever these names appear.
package avmm_pkg;

    // Word address width, 64 words
    localparam int ADDR_WIDTH = 6;

    // Data bus width and its byte enables
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Register stages between host and sink
    localparam int PIPE_STAGES = 2;

    // Request FIFO entries on the sink side
    localparam int FIFO_DEPTH = 8;

    // Requests still arriving after the sink raises waitrequest
    // One pipe depth for the waitrequest delay, one for requests already in flight
    localparam int WAIT_ALLOWANCE = 2 * PIPE_STAGES;

    // Request opcodes, idle means no request in this slot
    typedef enum logic [1:0]
    {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    // One single-word request
    typedef struct packed
    {
        mem_op_e                 op;
        logic [ADDR_WIDTH-1:0]   address;
        logic [DATA_WIDTH-1:0]   writedata;
        logic [BE_WIDTH-1:0]     byteenable;
    } avmm_req_t;

    // Read response, one pulse per read
    typedef struct packed
    {
        logic                    readdatavalid;
        logic [DATA_WIDTH-1:0]   readdata;
    } avmm_rsp_t;

endpackage

/* hdl/avmm_reg_pipe.sv */
// Register stages between host and sink for requests, responses and waitrequest.
// Waitrequest is delayed like the data, so the sink treats it as almost-full.
`timescale 1ns/1ps

module avmm_reg_pipe
#(
    parameter int N_REG_STAGES = avmm_pkg::PIPE_STAGES
)
(
    input  logic                mem_sink,
    input  logic                reset,
    input  avmm_pkg::avmm_req_t host_req,
    output logic                host_waitrequest,
    output avmm_pkg::avmm_req_t sink_req,
    input  logic                sink_waitrequest,
    input  avmm_pkg::avmm_rsp_t sink_rsp,
    output avmm_pkg::avmm_rsp_t host_rsp
);
    import avmm_pkg::*;

    // Request stages, index 0 is nearest the host
    avmm_req_t req_q [N_REG_STAGES];
    // Response stages, index 0 is nearest the sink
    avmm_rsp_t rsp_q [N_REG_STAGES];
    // Waitrequest delay line, sink value enters at bit 0
    logic [N_REG_STAGES-1:0] wait_q;
    // Host request qualified by waitrequest
    avmm_req_t req_in;

    // Only accepted requests enter the pipe
    always_comb
    begin
        req_in = host_req;
        if (host_waitrequest)
        begin
            req_in.op = OP_IDLE;
        end
    end

    always_ff @(posedge mem_sink)
    begin
        req_q[0] <= req_in;
        rsp_q[0] <= sink_rsp;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            req_q[s] <= req_q[s-1];
            rsp_q[s] <= rsp_q[s-1];
        end

        // Reset empties every stage: idle op, no valid response
        if (reset)
        begin
            for (int s = 0; s < N_REG_STAGES; s++)
            begin
                req_q[s].op <= OP_IDLE;
                rsp_q[s].readdatavalid <= 1'b0;
            end
        end
    end

    // Waitrequest shift register
    always_ff @(posedge mem_sink)
    begin
        if (reset)
        begin
            wait_q <= '0;
        end
        else
        begin
            wait_q[0] <= sink_waitrequest;
            for (int s = 1; s < N_REG_STAGES; s++)
            begin
                wait_q[s] <= wait_q[s-1];
            end
        end
    end

    assign sink_req = req_q[N_REG_STAGES-1];
    assign host_rsp = rsp_q[N_REG_STAGES-1];
    assign host_waitrequest = wait_q[N_REG_STAGES-1];

    // A request refused by waitrequest is held unchanged into the next cycle
    a_host_holds_request: assert property (
        @(posedge mem_sink) disable iff (reset)
        (host_waitrequest && host_req.op != OP_IDLE) |=> $stable(host_req)
    );

endmodule

/* hdl/req_fifo.sv */
// Circular request FIFO on the sink side of the pipe.
// Reports its free entry count so the controller can raise waitrequest early.
`timescale 1ns/1ps

module req_fifo
#(
    parameter int DEPTH = avmm_pkg::FIFO_DEPTH
)
(
    input  logic                         mem_sink,
    input  logic                         reset,
    input  logic                         push,
    input  avmm_pkg::avmm_req_t          push_data,
    input  logic                         pop,
    output avmm_pkg::avmm_req_t          head,
    output logic                         fifo_empty,
    output logic [$clog2(DEPTH+1)-1:0]   fifo_free
);
    import avmm_pkg::*;

    // Entry storage
    avmm_req_t entries [DEPTH];
    // Pointers wrap naturally, DEPTH is a power of two
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    // Occupied entries, 0 to DEPTH
    logic [$clog2(DEPTH+1)-1:0] count;

    // Storage write
    always_ff @(posedge mem_sink)
    begin
        if (push)
        begin
            entries[wr_ptr] <= push_data;
        end
    end

    // Pointer and occupancy tracking
    always_ff @(posedge mem_sink)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is read combinationally, a push shows up the next cycle
    assign head = entries[rd_ptr];
    assign fifo_empty = (count == '0);
    assign fifo_free = ($clog2(DEPTH+1))'(DEPTH) - count;

    // Upstream waitrequest allowance must keep the FIFO from overflowing
    a_no_push_full: assert property (
        @(posedge mem_sink) disable iff (reset)
        !(push && count == ($clog2(DEPTH+1))'(DEPTH))
    );

    a_no_pop_empty: assert property (
        @(posedge mem_sink) disable iff (reset)
        !(pop && fifo_empty)
    );

endmodule

/* hdl/mem_array.sv */
// Single-port word memory with byte-enabled writes and a registered read.
// Sits behind the sink controller as a model of a memory macro.
`timescale 1ns/1ps

module mem_array
(
    input  logic                          mem_sink,
    input  avmm_pkg::avmm_req_t           mem_cmd,
    output logic [avmm_pkg::DATA_WIDTH-1:0] rdata
);
    import avmm_pkg::*;

    // Word storage, power-up contents undefined
    logic [DATA_WIDTH-1:0] words [2**ADDR_WIDTH];

    always_ff @(posedge mem_sink)
    begin
        if (mem_cmd.op == OP_WRITE)
        begin
            // Byte lanes with enable set are updated, others keep old data
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (mem_cmd.byteenable[b])
                begin
                    words[mem_cmd.address][8*b +: 8] <= mem_cmd.writedata[8*b +: 8];
                end
            end
        end

        // Read data valid one cycle after the command
        if (mem_cmd.op == OP_READ)
        begin
            rdata <= words[mem_cmd.address];
        end
    end

endmodule

/* hdl/mem_ctrl.sv */
// Sink controller for the memory slave: pops requests, drives the array,
// forms read responses and raises waitrequest from the FIFO free count.
`timescale 1ns/1ps

module mem_ctrl
(
    input  logic                                          mem_sink,
    input  logic                                          reset,
    input  logic                                          drain_stall,
    input  avmm_pkg::avmm_req_t                           head,
    input  logic                                          fifo_empty,
    input  logic [$clog2(avmm_pkg::FIFO_DEPTH+1)-1:0]     fifo_free,
    input  logic [avmm_pkg::DATA_WIDTH-1:0]               rdata,
    output logic                                          pop,
    output avmm_pkg::avmm_req_t                           mem_cmd,
    output logic                                          sink_waitrequest,
    output avmm_pkg::avmm_rsp_t                           sink_rsp
);
    import avmm_pkg::*;

    // Read popped this cycle
    logic read_pop;
    // Reads in flight: bit 0 is array read, bit 1 is response register
    logic [1:0] rd_shift;
    // Response data register
    logic [DATA_WIDTH-1:0] rsp_data;

    // Drain whenever there is work and the memory is not busy
    assign pop = !fifo_empty && !drain_stall;
    assign read_pop = pop && (head.op == OP_READ);

    // Popped head goes straight to the array, otherwise idle
    always_comb
    begin
        mem_cmd = head;
        if (!pop)
        begin
            mem_cmd.op = OP_IDLE;
        end
    end

    // Almost-full: leave room for requests still in the pipe
    assign sink_waitrequest = (fifo_free <= ($bits(fifo_free))'(WAIT_ALLOWANCE));

    // Read tracking
    always_ff @(posedge mem_sink)
    begin
        if (reset)
        begin
            rd_shift <= '0;
        end
        else
        begin
            rd_shift <= {rd_shift[0], read_pop};
        end
    end

    // Capture array output the cycle it becomes valid
    always_ff @(posedge mem_sink)
    begin
        if (rd_shift[0])
        begin
            rsp_data <= rdata;
        end
    end

    assign sink_rsp.readdatavalid = rd_shift[1];
    assign sink_rsp.readdata = rsp_data;

    // Only accepted reads and writes ever leave the FIFO head
    a_pop_is_request: assert property (
        @(posedge mem_sink) disable iff (reset)
        pop |-> (head.op == OP_READ || head.op == OP_WRITE)
    );

endmodule

/* hdl/avmm_mem_top.sv */
// Top level of the memory slave: register pipe in front of FIFO, controller and array.
// Hosts connect on the host_* ports, drain_stall models a busy memory.
`timescale 1ns/1ps

module avmm_mem_top
(
    input  logic                mem_sink,
    input  logic                reset,
    input  logic                drain_stall,
    input  avmm_pkg::avmm_req_t host_req,
    output logic                host_waitrequest,
    output avmm_pkg::avmm_rsp_t host_rsp
);
    import avmm_pkg::*;

    // Sink side of the pipe
    avmm_req_t sink_req;
    avmm_rsp_t sink_rsp;
    logic      sink_waitrequest;

    // FIFO to controller
    logic                            fifo_push;
    avmm_req_t                       fifo_head;
    logic                            fifo_empty;
    logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free;
    logic                            pop;

    // Controller to array
    avmm_req_t             mem_cmd;
    logic [DATA_WIDTH-1:0] rdata;

    // Pipe only emits non-idle ops for accepted requests
    assign fifo_push = (sink_req.op != OP_IDLE);

    avmm_reg_pipe i_pipe (
        .mem_sink         (mem_sink),
        .reset            (reset),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .sink_req         (sink_req),
        .sink_waitrequest (sink_waitrequest),
        .sink_rsp         (sink_rsp),
        .host_rsp         (host_rsp)
    );

    req_fifo i_fifo (
        .mem_sink   (mem_sink),
        .reset      (reset),
        .push       (fifo_push),
        .push_data  (sink_req),
        .pop        (pop),
        .head       (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_free  (fifo_free)
    );

    mem_ctrl i_ctrl (
        .mem_sink         (mem_sink),
        .reset            (reset),
        .drain_stall      (drain_stall),
        .head             (fifo_head),
        .fifo_empty       (fifo_empty),
        .fifo_free        (fifo_free),
        .rdata            (rdata),
        .pop              (pop),
        .mem_cmd          (mem_cmd),
        .sink_waitrequest (sink_waitrequest),
        .sink_rsp         (sink_rsp)
    );

    mem_array i_mem (
        .mem_sink (mem_sink),
        .mem_cmd  (mem_cmd),
        .rdata    (rdata)
    );

endmodule

/* dv/tb_avmm_mem.sv */
// Table-driven testbench for the memory slave top level with a reference memory.
// Applies every table entry as a host request and checks read responses in order.
`timescale 1ns/1ps

module tb_avmm_mem;
    import avmm_pkg::*;

    // Table size and run limit
    localparam int NUM_ENTRIES = 68;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40;

    logic      mem_sink;
    logic      reset;
    logic      drain_stall;
    avmm_req_t host_req;
    logic      host_waitrequest;
    avmm_rsp_t host_rsp;

    // Stimulus table
    string     tbl_name  [NUM_ENTRIES];
    avmm_req_t tbl_req   [NUM_ENTRIES];
    int        tbl_stall [NUM_ENTRIES];
    int        n_entries;
    int        bp_first;
    int        bp_last;

    // Reference memory and outstanding reads
    logic [DATA_WIDTH-1:0] ref_mem [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] exp_q [$];
    string                 name_q [$];

    // Stall cycles still to hold, back-pressure seen flag, run length
    int   stall_left;
    logic wait_seen;
    int   cycle_count;

    avmm_mem_top i_dut (
        .mem_sink         (mem_sink),
        .reset            (reset),
        .drain_stall      (drain_stall),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .host_rsp         (host_rsp)
    );

    initial
    begin
        mem_sink = 1'b0;
        forever
        begin
            #2 mem_sink = ~mem_sink;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic add_entry(input string name, input mem_op_e op, input int addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input int stall);
        tbl_name[n_entries] = name;
        tbl_req[n_entries].op = op;
        tbl_req[n_entries].address = ADDR_WIDTH'(addr);
        tbl_req[n_entries].writedata = wdata;
        tbl_req[n_entries].byteenable = be;
        tbl_stall[n_entries] = stall;
        n_entries++;
    endtask

    task automatic build_table();
        int stall;
        // Full words at 0 to 7, later reads and random traffic rely on them
        for (int a = 0; a < 8; a++)
        begin
            add_entry("full_write", OP_WRITE, a, 32'hA5A50000 ^ (32'(a) * 32'h01030507),
                      4'hF, 0);
        end
        for (int a = 0; a < 8; a++)
        begin
            add_entry("full_read", OP_READ, a, 32'd0, 4'hF, 0);
        end
        // Byte lane merges on word 3
        add_entry("partial_write_b0", OP_WRITE, 3, 32'h000000C3, 4'b0001, 0);
        add_entry("partial_read_b0", OP_READ, 3, 32'd0, 4'hF, 0);
        add_entry("partial_write_b12", OP_WRITE, 3, 32'h00DEAD00, 4'b0110, 0);
        add_entry("partial_read_b12", OP_READ, 3, 32'd0, 4'hF, 0);
        add_entry("partial_write_b3", OP_WRITE, 3, 32'h7F000000, 4'b1000, 0);
        add_entry("partial_read_b3", OP_READ, 3, 32'd0, 4'hF, 0);
        add_entry("partial_write_none", OP_WRITE, 3, 32'hFFFFFFFF, 4'b0000, 0);
        add_entry("partial_read_none", OP_READ, 3, 32'd0, 4'hF, 0);
        // Long stall after the first write, the rest queue up behind it
        bp_first = n_entries;
        for (int a = 16; a < 26; a++)
        begin
            add_entry("backpressure_write", OP_WRITE, a, 32'hB00D0000 + 32'(a), 4'hF,
                      (a == 16) ? 32 : 0);
        end
        bp_last = n_entries - 1;
        for (int a = 16; a < 26; a++)
        begin
            add_entry("backpressure_read", OP_READ, a, 32'd0, 4'hF, 0);
        end
        // Mixed traffic on the words already written
        for (int k = 0; k < 24; k++)
        begin
            stall = ($urandom_range(3, 0) == 0) ? int'($urandom_range(6, 1)) : 0;
            add_entry("random_traffic", ($urandom_range(1, 0) == 0) ? OP_READ : OP_WRITE,
                      int'($urandom_range(7, 0)), $urandom, 4'($urandom_range(15, 0)), stall);
        end
    endtask

    // Called at the falling edge before the accepting rising edge
    task automatic record_accept(input int idx);
        if (tbl_req[idx].op == OP_WRITE)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (tbl_req[idx].byteenable[b])
                begin
                    ref_mem[tbl_req[idx].address][8*b +: 8] = tbl_req[idx].writedata[8*b +: 8];
                end
            end
        end
        else if (tbl_req[idx].op == OP_READ)
        begin
            exp_q.push_back(ref_mem[tbl_req[idx].address]);
            name_q.push_back(tbl_name[idx]);
        end
        if (tbl_stall[idx] > stall_left)
        begin
            stall_left = tbl_stall[idx];
        end
    endtask

    // Entered just after a rising edge, held until waitrequest lets it through
    task automatic send_entry(input int idx);
        logic accepted;
        accepted = 1'b0;
        host_req = tbl_req[idx];
        while (!accepted)
        begin
            @(negedge mem_sink);
            if (!host_waitrequest)
            begin
                accepted = 1'b1;
                record_accept(idx);
            end
            @(posedge mem_sink);
            #1;
        end
    endtask

    // Drain stall driver
    always @(posedge mem_sink)
    begin
        #1;
        drain_stall = (stall_left > 0);
        if (stall_left > 0)
        begin
            stall_left = stall_left - 1;
        end
    end

    // Response checker, outputs are settled mid-cycle
    always @(negedge mem_sink)
    begin
        if (!reset && host_waitrequest === 1'b1)
        begin
            wait_seen = 1'b1;
        end
        if (!reset && host_rsp.readdatavalid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("read response arrived with no read outstanding");
                $display("Something failed");
                $fatal(1, "unexpected response");
            end
            check(name_q.pop_front(), exp_q.pop_front(), host_rsp.readdata);
        end
    end

    // Run limit
    always @(posedge mem_sink)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        int seed_init;
        int gap;
        reset = 1'b1;
        drain_stall = 1'b0;
        host_req = '0;
        host_req.op = OP_IDLE;
        n_entries = 0;
        stall_left = 0;
        wait_seen = 1'b0;
        cycle_count = 0;
        seed_init = $urandom(1473);
        build_table();

        repeat (4) @(posedge mem_sink);
        #1;
        reset = 1'b0;
        @(negedge mem_sink);
        check("reset_waitrequest", 32'd0, 32'(host_waitrequest));
        check("reset_readdatavalid", 32'd0, 32'(host_rsp.readdatavalid));
        @(posedge mem_sink);
        #1;

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            if (i == bp_first)
            begin
                wait_seen = 1'b0;
            end
            send_entry(i);
            if (i == bp_last)
            begin
                check("backpressure_waitrequest", 32'd1, 32'(wait_seen));
            end
            // Idle gaps only in the random section
            gap = (tbl_name[i] == "random_traffic") ? int'($urandom_range(3, 0)) : 0;
            host_req.op = OP_IDLE;
            repeat (gap)
            begin
                @(posedge mem_sink);
                #1;
            end
        end
        host_req.op = OP_IDLE;

        // Let outstanding reads come back, then look for stray responses
        while (exp_q.size() != 0)
        begin
            @(negedge mem_sink);
        end
        repeat (12) @(negedge mem_sink);
        $display("Everything OK");
        $finish;
    end

endmodule

/* sim.f */
hdl/avmm_pkg.sv
hdl/avmm_reg_pipe.sv
hdl/req_fifo.sv
hdl/mem_array.sv
hdl/mem_ctrl.sv
hdl/avmm_mem_top.sv
dv/tb_avmm_mem.sv

/* Makefile */
# Verilator build and run for the memory slave testbench

VERILATOR ?= verilator
TOP       ?= tb_avmm_mem
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
